// File: src/idr_macros.svh
`ifndef IDR_MACROS_SVH
`define IDR_MACROS_SVH

// Master and slave side ID widths
`define ID_IN_W     6
`define ID_OUT_W    2

// Slots per direction, at most 2**ID_OUT_W
`define TABLE_DEPTH 4

`define ADDR_W      16
`define DATA_W      32
`define USER_W      1

`endif

// File: src/idr_pkg.sv
`default_nettype none
`include "idr_macros.svh"

package idr_pkg;

    // Request fields without ID and handshake
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [7:0]         len;
        logic [2:0]         size;
        logic [1:0]         burst;
        logic               lock;
        logic [3:0]         cache;
        logic [2:0]         prot;
        logic [3:0]         qos;
        logic [3:0]         region;
        logic [`USER_W-1:0] user;
    } aw_fields_t;

    typedef aw_fields_t ar_fields_t;  // Same layout as AW

    typedef struct packed {
        logic [`DATA_W-1:0]   data;
        logic [`DATA_W/8-1:0] strb;
        logic                 last;
        logic [`USER_W-1:0]   user;
    } w_chan_t;

    typedef struct packed {
        logic [1:0]         resp;
        logic [`USER_W-1:0] user;
    } b_fields_t;

    typedef struct packed {
        logic [`DATA_W-1:0] data;
        logic [1:0]         resp;
        logic               last;
        logic [`USER_W-1:0] user;
    } r_fields_t;

    // addr 0 is the write limit, addr 1 the read limit
    typedef struct packed {
        logic       en;
        logic       addr;
        logic [2:0] data;
    } cfg_wr_t;

    typedef struct packed {
        logic [2:0] wr_count;
        logic [2:0] rd_count;
        logic [2:0] wr_limit;
        logic [2:0] rd_limit;
        logic       stray_b;
        logic       stray_r;
    } idr_status_t;

    typedef struct packed {
        logic [2:0] wr_limit;
        logic [2:0] rd_limit;
    } idr_limits_t;

endpackage

`default_nettype wire

// File: src/id_remap_table.sv
`default_nettype none
`include "idr_macros.svh"

module id_remap_table (
    input  wire                  clk_i,
    input  wire                  rst_ni,
    input  wire                  alloc_i,
    input  wire  [`ID_IN_W-1:0]  orig_id_i,
    input  wire                  release_i,
    input  wire  [`ID_OUT_W-1:0] rel_id_i,
    output logic                 free_o,
    output logic [`ID_OUT_W-1:0] alloc_id_o,
    output logic                 rel_valid_o,
    output logic [`ID_IN_W-1:0]  rel_orig_id_o,
    output logic [2:0]           count_o
);

    typedef logic [`ID_OUT_W-1:0] slot_t;

    logic [`TABLE_DEPTH-1:0] valid_q;
    logic [`TABLE_DEPTH-1:0] valid_d;
    logic [`ID_IN_W-1:0]     orig_q [`TABLE_DEPTH];
    logic [2:0]              count_q;

    assign free_o = ~&valid_q;

    // Scan down so the lowest free index is left standing
    always_comb begin
        alloc_id_o = '0;
        for (int i = `TABLE_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                alloc_id_o = slot_t'(i);
            end
        end
    end

    // Response side lookup
    assign rel_valid_o   = valid_q[rel_id_i];
    assign rel_orig_id_o = orig_q[rel_id_i];

    // Alloc hits a free slot, release a held one, so they never collide
    always_comb begin
        valid_d = valid_q;
        if (alloc_i) begin
            valid_d[alloc_id_o] = 1'b1;
        end
        if (release_i) begin
            valid_d[rel_id_i] = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            count_q <= '0;
        end else begin
            valid_q <= valid_d;
            count_q <= count_q + {2'b00, alloc_i} - {2'b00, release_i};  // Net change
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            orig_q[alloc_id_o] <= orig_id_i;  // Original master ID
        end
    end

    assign count_o = count_q;

endmodule

`default_nettype wire

// File: src/id_remap_cfg.sv
`default_nettype none
`include "idr_macros.svh"

module id_remap_cfg
    import idr_pkg::*;
(
    input  wire          clk_i,
    input  wire          rst_ni,
    input  wire cfg_wr_t cfg_i,
    input  wire  [2:0]   wr_count_i,
    input  wire  [2:0]   rd_count_i,
    input  wire          stray_b_i,
    input  wire          stray_r_i,
    output idr_limits_t  limits_o,
    output idr_status_t  status_o
);

    localparam logic [2:0] max_limit = 3'(`TABLE_DEPTH);

    logic [2:0] wr_limit_q;
    logic [2:0] rd_limit_q;
    logic [2:0] limit_val;
    logic       stray_b_q;
    logic       stray_r_q;

    // Zero or oversize means full table
    assign limit_val = (cfg_i.data == 3'd0 || cfg_i.data > max_limit) ? max_limit
                                                                      : cfg_i.data;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_limit_q <= max_limit;
            rd_limit_q <= max_limit;
            stray_b_q  <= 1'b0;
            stray_r_q  <= 1'b0;
        end else begin
            if (cfg_i.en && !cfg_i.addr) begin
                wr_limit_q <= limit_val;
            end
            if (cfg_i.en && cfg_i.addr) begin
                rd_limit_q <= limit_val;
            end
            // Sticky until reset
            stray_b_q <= stray_b_q | stray_b_i;
            stray_r_q <= stray_r_q | stray_r_i;
        end
    end

    assign limits_o.wr_limit = wr_limit_q;
    assign limits_o.rd_limit = rd_limit_q;

    assign status_o.wr_count = wr_count_i;  // Already registered in the tables
    assign status_o.rd_count = rd_count_i;
    assign status_o.wr_limit = wr_limit_q;
    assign status_o.rd_limit = rd_limit_q;
    assign status_o.stray_b  = stray_b_q;
    assign status_o.stray_r  = stray_r_q;

endmodule

`default_nettype wire

// File: src/axi_id_remap.sv
`default_nettype none
`include "idr_macros.svh"

module axi_id_remap
    import idr_pkg::*;
(
    input  wire                     clk_i,
    input  wire                     rst_ni,
    input  wire idr_limits_t        limits_i,
    // Master side
    input  wire aw_fields_t         mst_aw_i,
    input  wire  [`ID_IN_W-1:0]     mst_aw_id_i,
    input  wire                     mst_aw_valid_i,
    output logic                    mst_aw_ready_o,
    input  wire w_chan_t            mst_w_i,
    input  wire                     mst_w_valid_i,
    output logic                    mst_w_ready_o,
    output b_fields_t               mst_b_o,
    output logic [`ID_IN_W-1:0]     mst_b_id_o,
    output logic                    mst_b_valid_o,
    input  wire                     mst_b_ready_i,
    input  wire ar_fields_t         mst_ar_i,
    input  wire  [`ID_IN_W-1:0]     mst_ar_id_i,
    input  wire                     mst_ar_valid_i,
    output logic                    mst_ar_ready_o,
    output r_fields_t               mst_r_o,
    output logic [`ID_IN_W-1:0]     mst_r_id_o,
    output logic                    mst_r_valid_o,
    input  wire                     mst_r_ready_i,
    // Slave side
    output aw_fields_t              slv_aw_o,
    output logic [`ID_OUT_W-1:0]    slv_aw_id_o,
    output logic                    slv_aw_valid_o,
    input  wire                     slv_aw_ready_i,
    output w_chan_t                 slv_w_o,
    output logic                    slv_w_valid_o,
    input  wire                     slv_w_ready_i,
    input  wire b_fields_t          slv_b_i,
    input  wire  [`ID_OUT_W-1:0]    slv_b_id_i,
    input  wire                     slv_b_valid_i,
    output logic                    slv_b_ready_o,
    output ar_fields_t              slv_ar_o,
    output logic [`ID_OUT_W-1:0]    slv_ar_id_o,
    output logic                    slv_ar_valid_o,
    input  wire                     slv_ar_ready_i,
    input  wire r_fields_t          slv_r_i,
    input  wire  [`ID_OUT_W-1:0]    slv_r_id_i,
    input  wire                     slv_r_valid_i,
    output logic                    slv_r_ready_o,
    // Occupancy and stray pulses
    output logic [2:0]              wr_count_o,
    output logic [2:0]              rd_count_o,
    output logic                    stray_b_o,
    output logic                    stray_r_o
);

    logic wr_free, wr_open, wr_hit, wr_alloc, wr_release;
    logic rd_free, rd_open, rd_hit, rd_alloc, rd_release;

    // Payload straight through
    assign slv_aw_o      = mst_aw_i;
    assign slv_ar_o      = mst_ar_i;
    assign slv_w_o       = mst_w_i;
    assign slv_w_valid_o = mst_w_valid_i;
    assign mst_w_ready_o = slv_w_ready_i;
    assign mst_b_o       = slv_b_i;
    assign mst_r_o       = slv_r_i;

    // Address channels stall when full or at the limit
    assign wr_open        = wr_free & (wr_count_o < limits_i.wr_limit);
    assign slv_aw_valid_o = mst_aw_valid_i & wr_open;
    assign mst_aw_ready_o = slv_aw_ready_i & wr_open;
    assign wr_alloc       = mst_aw_valid_i & slv_aw_ready_i & wr_open;

    assign rd_open        = rd_free & (rd_count_o < limits_i.rd_limit);
    assign slv_ar_valid_o = mst_ar_valid_i & rd_open;
    assign mst_ar_ready_o = slv_ar_ready_i & rd_open;
    assign rd_alloc       = mst_ar_valid_i & slv_ar_ready_i & rd_open;

    // Responses for a free slot are held back
    assign mst_b_valid_o = slv_b_valid_i & wr_hit;
    assign slv_b_ready_o = mst_b_ready_i & wr_hit;
    assign wr_release    = slv_b_valid_i & mst_b_ready_i & wr_hit;
    assign stray_b_o     = slv_b_valid_i & ~wr_hit;

    assign mst_r_valid_o = slv_r_valid_i & rd_hit;
    assign slv_r_ready_o = mst_r_ready_i & rd_hit;
    assign rd_release    = slv_r_valid_i & mst_r_ready_i & rd_hit & slv_r_i.last;  // Last beat only
    assign stray_r_o     = slv_r_valid_i & ~rd_hit;

    id_remap_table u_wr_table (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .alloc_i       (wr_alloc),
        .orig_id_i     (mst_aw_id_i),
        .release_i     (wr_release),
        .rel_id_i      (slv_b_id_i),
        .free_o        (wr_free),
        .alloc_id_o    (slv_aw_id_o),
        .rel_valid_o   (wr_hit),
        .rel_orig_id_o (mst_b_id_o),
        .count_o       (wr_count_o)
    );

    id_remap_table u_rd_table (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .alloc_i       (rd_alloc),
        .orig_id_i     (mst_ar_id_i),
        .release_i     (rd_release),
        .rel_id_i      (slv_r_id_i),
        .free_o        (rd_free),
        .alloc_id_o    (slv_ar_id_o),
        .rel_valid_o   (rd_hit),
        .rel_orig_id_o (mst_r_id_o),
        .count_o       (rd_count_o)
    );

endmodule

`default_nettype wire

// File: src/idr_top.sv
`default_nettype none
`include "idr_macros.svh"

module idr_top
    import idr_pkg::*;
(
    input  wire                     clk_i,
    input  wire                     rst_ni,
    // Master side
    input  wire aw_fields_t         mst_aw_i,
    input  wire  [`ID_IN_W-1:0]     mst_aw_id_i,
    input  wire                     mst_aw_valid_i,
    output logic                    mst_aw_ready_o,
    input  wire w_chan_t            mst_w_i,
    input  wire                     mst_w_valid_i,
    output logic                    mst_w_ready_o,
    output b_fields_t               mst_b_o,
    output logic [`ID_IN_W-1:0]     mst_b_id_o,
    output logic                    mst_b_valid_o,
    input  wire                     mst_b_ready_i,
    input  wire ar_fields_t         mst_ar_i,
    input  wire  [`ID_IN_W-1:0]     mst_ar_id_i,
    input  wire                     mst_ar_valid_i,
    output logic                    mst_ar_ready_o,
    output r_fields_t               mst_r_o,
    output logic [`ID_IN_W-1:0]     mst_r_id_o,
    output logic                    mst_r_valid_o,
    input  wire                     mst_r_ready_i,
    // Slave side
    output aw_fields_t              slv_aw_o,
    output logic [`ID_OUT_W-1:0]    slv_aw_id_o,
    output logic                    slv_aw_valid_o,
    input  wire                     slv_aw_ready_i,
    output w_chan_t                 slv_w_o,
    output logic                    slv_w_valid_o,
    input  wire                     slv_w_ready_i,
    input  wire b_fields_t          slv_b_i,
    input  wire  [`ID_OUT_W-1:0]    slv_b_id_i,
    input  wire                     slv_b_valid_i,
    output logic                    slv_b_ready_o,
    output ar_fields_t              slv_ar_o,
    output logic [`ID_OUT_W-1:0]    slv_ar_id_o,
    output logic                    slv_ar_valid_o,
    input  wire                     slv_ar_ready_i,
    input  wire r_fields_t          slv_r_i,
    input  wire  [`ID_OUT_W-1:0]    slv_r_id_i,
    input  wire                     slv_r_valid_i,
    output logic                    slv_r_ready_o,
    // Configuration and status
    input  wire cfg_wr_t            cfg_i,
    output idr_status_t             status_o
);

    idr_limits_t limits;
    logic [2:0]  wr_count;
    logic [2:0]  rd_count;
    logic        stray_b;
    logic        stray_r;

    // Channel ports connect by name
    axi_id_remap u_remap (
        .limits_i   (limits),
        .wr_count_o (wr_count),
        .rd_count_o (rd_count),
        .stray_b_o  (stray_b),
        .stray_r_o  (stray_r),
        .*
    );

    id_remap_cfg u_cfg (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .cfg_i      (cfg_i),
        .wr_count_i (wr_count),
        .rd_count_i (rd_count),
        .stray_b_i  (stray_b),
        .stray_r_i  (stray_r),
        .limits_o   (limits),
        .status_o   (status_o)
    );

endmodule

`default_nettype wire

// File: verif/idr_tb.sv
`default_nettype none
`include "idr_macros.svh"

module idr_tb
    import idr_pkg::*;
();

    localparam int depth = `TABLE_DEPTH;

    typedef struct packed {
        byte                 op;
        logic [`ID_IN_W-1:0] id;
        logic [`ADDR_W-1:0]  addr;
        logic [7:0]          len;
        int                  dly;
    } case_t;

    logic clk_i, rst_ni;
    aw_fields_t mst_aw_i, slv_aw_o;
    ar_fields_t mst_ar_i, slv_ar_o;
    w_chan_t    mst_w_i, slv_w_o;
    b_fields_t  mst_b_o, slv_b_i;
    r_fields_t  mst_r_o, slv_r_i;
    logic [`ID_IN_W-1:0]  mst_aw_id_i, mst_ar_id_i, mst_b_id_o, mst_r_id_o;
    logic [`ID_OUT_W-1:0] slv_aw_id_o, slv_ar_id_o, slv_b_id_i, slv_r_id_i;
    logic mst_aw_valid_i, mst_aw_ready_o, mst_w_valid_i, mst_w_ready_o;
    logic mst_b_valid_o, mst_b_ready_i, mst_ar_valid_i, mst_ar_ready_o;
    logic mst_r_valid_o, mst_r_ready_i;
    logic slv_aw_valid_o, slv_aw_ready_i, slv_w_valid_o, slv_w_ready_i;
    logic slv_b_valid_i, slv_b_ready_o, slv_ar_valid_o, slv_ar_ready_i;
    logic slv_r_valid_i, slv_r_ready_o;
    cfg_wr_t     cfg_i;
    idr_status_t status_o;

    // Index 0 is the write side and 1 the read side
    logic [depth-1:0]    held [2];
    logic [`ID_IN_W-1:0] orig [2][depth];
    logic [7:0]          rd_len [depth];
    logic [2:0]          limit [2];
    logic                stray_exp [2];
    int                  pend_w[$];
    int                  pend_r[$];
    logic [31:0]         seed = 32'h3642;
    int                  n_cases = 0;

    idr_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        wait (n_cases > 0);
        repeat (n_cases * 200) @(posedge clk_i);
        $display("Watchdog expired, the run took longer than %0d cases allow", n_cases);
        $display("TEST FAILED");
        $fatal(1);
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = next_rand();
        return r[31];  // Low LCG bits are weak
    endfunction

    function automatic logic is_open(int s);
        int n;
        n = $countones(held[s]);
        return n < depth && n < int'(limit[s]);
    endfunction

    function automatic int lowest_free(int s);
        for (int i = 0; i < depth; i++) begin
            if (!held[s][i]) return i;
        end
        return -1;
    endfunction

    task automatic abort(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(string name, logic [63:0] exp, logic [63:0] got);
        assert (got === exp) else begin
            $display("MISMATCH %s exp=%h got=%h", name, exp, got);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Gating and status against the scoreboard
    task automatic settle();
        #1;
        check_eq("mst_aw_ready_o", slv_aw_ready_i & is_open(0), mst_aw_ready_o);
        check_eq("slv_aw_valid_o", mst_aw_valid_i & is_open(0), slv_aw_valid_o);
        check_eq("mst_ar_ready_o", slv_ar_ready_i & is_open(1), mst_ar_ready_o);
        check_eq("slv_ar_valid_o", mst_ar_valid_i & is_open(1), slv_ar_valid_o);
        check_eq("slv_w_valid_o", mst_w_valid_i, slv_w_valid_o);
        check_eq("mst_w_ready_o", slv_w_ready_i, mst_w_ready_o);
        check_eq("mst_b_valid_o", slv_b_valid_i & held[0][slv_b_id_i], mst_b_valid_o);
        check_eq("mst_r_valid_o", slv_r_valid_i & held[1][slv_r_id_i], mst_r_valid_o);
        check_eq("slv_b_ready_o", mst_b_ready_i & held[0][slv_b_id_i], slv_b_ready_o);
        check_eq("slv_r_ready_o", mst_r_ready_i & held[1][slv_r_id_i], slv_r_ready_o);
        check_eq("status_o.wr_count", $countones(held[0]), status_o.wr_count);
        check_eq("status_o.rd_count", $countones(held[1]), status_o.rd_count);
        check_eq("status_o.wr_limit", limit[0], status_o.wr_limit);
        check_eq("status_o.rd_limit", limit[1], status_o.rd_limit);
        check_eq("status_o.stray_b", stray_exp[0], status_o.stray_b);
        check_eq("status_o.stray_r", stray_exp[1], status_o.stray_r);
    endtask

    task automatic write_cfg(logic sel, logic [2:0] val);
        @(negedge clk_i);
        cfg_i = '{en: 1'b1, addr: sel, data: val};
        settle();
        @(negedge clk_i);
        cfg_i = '0;
        limit[sel] = (val == 3'd0 || int'(val) > depth) ? 3'(depth) : val;  // Clamp rule
        settle();
    endtask

    task automatic start_req(logic rd, logic [`ID_IN_W-1:0] id, logic [15:0] addr,
                             logic [7:0] len);
        aw_fields_t f;
        f = '0;
        f.addr = addr;
        f.len = len;
        f.size = 3'd2;
        f.burst = 2'b01;
        f.qos = 4'(next_rand());
        f.user = rand_bit();
        @(negedge clk_i);
        if (rd) begin
            mst_ar_i = f;
            mst_ar_id_i = id;
            mst_ar_valid_i = 1'b1;
        end else begin
            mst_aw_i = f;
            mst_aw_id_i = id;
            mst_aw_valid_i = 1'b1;
        end
    endtask

    task automatic finish_write(int gap);
        int slot;
        int waited;
        waited = 0;
        forever begin
            slv_aw_ready_i = (gap <= waited);
            settle();
            if (mst_aw_ready_o) break;
            waited++;
            @(negedge clk_i);
        end
        slot = lowest_free(0);
        check_eq("slv_aw_id_o", slot, slv_aw_id_o);
        check_eq("slv_aw_o", mst_aw_i, slv_aw_o);
        held[0][slot] = 1'b1;
        orig[0][slot] = mst_aw_id_i;
        pend_w.push_back(slot);
        for (int i = 0; i <= int'(mst_aw_i.len); i++) begin
            @(negedge clk_i);
            mst_aw_valid_i = 1'b0;
            slv_aw_ready_i = 1'b0;
            mst_w_i = '{data: next_rand(), strb: '1, last: (i == int'(mst_aw_i.len)), user: '0};
            mst_w_valid_i = 1'b1;
            forever begin
                slv_w_ready_i = rand_bit() | rand_bit();
                settle();
                check_eq("slv_w_o", mst_w_i, slv_w_o);
                if (slv_w_ready_i) break;
                @(negedge clk_i);
            end
        end
        @(negedge clk_i);
        mst_w_valid_i = 1'b0;
        slv_w_ready_i = 1'b0;
    endtask

    task automatic finish_read(int gap);
        int slot;
        int waited;
        waited = 0;
        forever begin
            slv_ar_ready_i = (gap <= waited);
            settle();
            if (mst_ar_ready_o) break;
            waited++;
            @(negedge clk_i);
        end
        slot = lowest_free(1);
        check_eq("slv_ar_id_o", slot, slv_ar_id_o);
        check_eq("slv_ar_o", mst_ar_i, slv_ar_o);
        held[1][slot] = 1'b1;
        orig[1][slot] = mst_ar_id_i;
        rd_len[slot] = mst_ar_i.len;
        pend_r.push_back(slot);
        @(negedge clk_i);
        mst_ar_valid_i = 1'b0;
        slv_ar_ready_i = 1'b0;
    endtask

    // Slave answers a random outstanding write
    task automatic answer_write();
        int k;
        int slot;
        k = int'(next_rand() % 32'(pend_w.size()));
        slot = pend_w[k];
        pend_w.delete(k);
        @(negedge clk_i);
        slv_b_i = '{resp: 2'(next_rand() >> 20), user: rand_bit()};
        slv_b_id_i = 2'(slot);
        slv_b_valid_i = 1'b1;
        forever begin
            mst_b_ready_i = rand_bit() | rand_bit();
            settle();
            check_eq("mst_b_id_o", orig[0][slot], mst_b_id_o);
            check_eq("mst_b_o", slv_b_i, mst_b_o);
            if (mst_b_ready_i) break;
            @(negedge clk_i);
        end
        held[0][slot] = 1'b0;
        @(negedge clk_i);
        slv_b_valid_i = 1'b0;
        mst_b_ready_i = 1'b0;
    endtask

    task automatic answer_read();
        int k;
        int slot;
        k = int'(next_rand() % 32'(pend_r.size()));
        slot = pend_r[k];
        pend_r.delete(k);
        for (int i = 0; i <= int'(rd_len[slot]); i++) begin
            @(negedge clk_i);
            slv_r_i.data = next_rand();
            slv_r_i.resp = 2'(next_rand() >> 20);
            slv_r_i.last = (i == int'(rd_len[slot]));
            slv_r_i.user = rand_bit();
            slv_r_id_i = 2'(slot);
            slv_r_valid_i = 1'b1;
            forever begin
                mst_r_ready_i = rand_bit() | rand_bit();
                settle();
                check_eq("mst_r_id_o", orig[1][slot], mst_r_id_o);
                check_eq("mst_r_o", slv_r_i, mst_r_o);
                if (mst_r_ready_i) break;
                @(negedge clk_i);
            end
        end
        held[1][slot] = 1'b0;  // Only the last beat frees the slot
        @(negedge clk_i);
        slv_r_valid_i = 1'b0;
        mst_r_ready_i = 1'b0;
    endtask

    task automatic send_stray(int s, logic [1:0] id, int cycles);
        if (held[s][id]) abort("Stray response case names a slot that is held");
        @(negedge clk_i);
        slv_b_id_i = id;
        slv_r_id_i = id;
        slv_r_i.last = 1'b1;
        slv_b_valid_i = (s == 0);
        slv_r_valid_i = (s == 1);
        mst_b_ready_i = 1'b1;
        mst_r_ready_i = 1'b1;
        repeat (cycles) begin
            settle();
            stray_exp[s] = 1'b1;
            @(negedge clk_i);
        end
        slv_b_valid_i = 1'b0;
        slv_r_valid_i = 1'b0;
        mst_b_ready_i = 1'b0;
        mst_r_ready_i = 1'b0;
        settle();
    endtask

    initial begin
        int fd;
        string line;
        byte op;
        logic [`ID_IN_W-1:0] id;
        logic [15:0] addr;
        logic [7:0] len;
        int dly;
        case_t c;
        case_t cases[$];

        rst_ni = 1'b0;
        {mst_aw_i, mst_aw_id_i, mst_aw_valid_i, mst_w_i, mst_w_valid_i} = '0;
        {mst_ar_i, mst_ar_id_i, mst_ar_valid_i, mst_b_ready_i, mst_r_ready_i} = '0;
        {slv_aw_ready_i, slv_w_ready_i, slv_ar_ready_i} = '0;
        {slv_b_i, slv_b_id_i, slv_b_valid_i, slv_r_i, slv_r_id_i, slv_r_valid_i} = '0;
        cfg_i = '0;
        held = '{default: '0};
        limit = '{default: 3'(depth)};
        stray_exp = '{default: 1'b0};

        fd = $fopen("verif/idr_cases.txt", "r");
        if (fd == 0) abort("Cannot open verif/idr_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            void'($sscanf(line, "%c %h %h %h %d", op, id, addr, len, dly));
            c = '{op, id, addr, len, dly};
            cases.push_back(c);
        end
        $fclose(fd);
        n_cases = cases.size();

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        settle();

        foreach (cases[i]) begin
            c = cases[i];
            case (c.op)
                "c": write_cfg(c.id[0], c.len[2:0]);
                "w": begin
                    start_req(1'b0, c.id, c.addr, c.len);
                    finish_write(c.dly);
                end
                "r": begin
                    start_req(1'b1, c.id, c.addr, c.len);
                    finish_read(c.dly);
                end
                "k": begin
                    if (is_open(0)) abort("Write stall case while a write slot is open");
                    start_req(1'b0, c.id, c.addr, c.len);
                    slv_aw_ready_i = 1'b1;
                    repeat (c.dly) begin
                        settle();
                        @(negedge clk_i);
                    end
                    answer_write();
                    finish_write(0);
                end
                "j": begin
                    if (is_open(1)) abort("Read stall case while a read slot is open");
                    start_req(1'b1, c.id, c.addr, c.len);
                    slv_ar_ready_i = 1'b1;
                    repeat (c.dly) begin
                        settle();
                        @(negedge clk_i);
                    end
                    answer_read();
                    finish_read(0);
                end
                "f": begin
                    while (pend_w.size() > 0 || pend_r.size() > 0) begin
                        if (pend_r.size() == 0 || (pend_w.size() > 0 && rand_bit())) begin
                            answer_write();
                        end else begin
                            answer_read();
                        end
                    end
                end
                "b": send_stray(0, c.id[1:0], c.dly);
                "s": send_stray(1, c.id[1:0], c.dly);
                default: abort("Unknown operation in the case file");
            endcase
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/idr_cases.txt
# op id addr len delay: id, addr, len in hex, delay in cycles
# c=config (id 0 write, 1 read limit; len value) w/r=request k/j=stall f=answer all b/s=stray
w 05 1000 00 0
w 2a 1004 01 2
r 11 2000 03 0
w 3f 1008 00 1
r 07 2010 00 3
f 00 0000 00 0
w 01 1100 00 0
w 02 1104 00 0
w 03 1108 02 1
w 04 110c 00 0
k 09 1110 00 3
f 00 0000 00 0
r 10 2100 01 0
r 20 2104 02 0
r 30 2108 00 2
r 3e 210c 03 0
j 0c 2110 00 2
f 00 0000 00 0
c 01 0000 02 0
r 12 2200 02 0
r 13 2204 00 1
j 14 2208 01 4
f 00 0000 00 0
c 01 0000 00 0
c 00 0000 01 0
w 18 1300 00 0
k 19 1304 01 2
f 00 0000 00 0
c 00 0000 07 0
w 15 1200 00 0
b 03 0000 00 3
s 02 0000 00 2
f 00 0000 00 0
w 16 1204 00 0
r 17 2300 00 0
f 00 0000 00 0

// File: sim.f
+incdir+src
src/idr_pkg.sv
src/id_remap_table.sv
src/id_remap_cfg.sv
src/axi_id_remap.sv
src/idr_top.sv
verif/idr_tb.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP      ?= idr_tb
FILELIST ?= sim.f
BUILD    := obj_dir

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

# Simulator exit status carries pass or fail
sim:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
